/* hw/lfsr_pkg.sv */
// data word definitions for the pattern source
// word width, word type and a reference tap mask
`default_nettype none

package lfsr_pkg;

    localparam int LFSR_WIDTH = 16;

    typedef logic [LFSR_WIDTH-1:0] lfsr_word_t;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    // fibonacci taps on bits 15, 13, 12 and 10 for a left shifting register
    localparam lfsr_word_t LFSR_DEFAULT_POLY = 16'hB400;

endpackage

`default_nettype wire

/* hw/crc_pkg.sv */
// checksum and stream definitions
// crc width and init, stream beat and result structs, crc-16 word update
`default_nettype none

package crc_pkg;

    import lfsr_pkg::*;

    localparam int CRC_WIDTH       = 16;
    localparam int FRAME_LEN_WIDTH = 8;

    typedef logic [CRC_WIDTH-1:0] crc_t;

    localparam crc_t CRC_INIT = '1;       // preset at start of every frame
    localparam crc_t CRC_POLY = 16'h1021; // x^16 + x^12 + x^5 + 1, top bit implied

    // one beat between tagger, engine and output
    typedef struct packed {
        lfsr_word_t data;
        logic       last; // final word of a frame
    } stream_beat_t;

    // checksum report at frame close
    typedef struct packed {
        crc_t                       crc;
        logic [FRAME_LEN_WIDTH-1:0] count; // words in the frame, 256 reads as 0
    } crc_result_t;

    // fold one word into the crc, msb first, no reflection
    function automatic crc_t crc16_word(input crc_t crc_in, input lfsr_word_t data);
        crc_t crc;
        logic fb;
        crc = crc_in;
        for (int i = LFSR_WIDTH - 1; i >= 0; i--) begin
            fb  = crc[CRC_WIDTH-1] ^ data[i];
            crc = crc << 1;
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

/* hw/lfsr_source.sv */
// fibonacci lfsr pattern source with valid/ready output
// seed and taps are taken while in reset
`timescale 1ns/1ns
`default_nettype none

module lfsr_source
    import lfsr_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rstn_i,
    input  wire logic       enable_i,
    input  wire lfsr_word_t seed_i,
    input  wire lfsr_word_t poly_i,
    output logic            valid_o,
    output lfsr_word_t      word_o,
    input  wire logic       ready_i
);

    lfsr_word_t word_q;
    lfsr_word_t poly_q;
    logic       valid_q;
    logic       handshake;
    logic       feedback;
    lfsr_word_t word_next;

    assign handshake = valid_q & ready_i;

    // parity of the tapped bits enters at the bottom
    assign feedback  = ^(word_q & poly_q);
    assign word_next = {word_q[LFSR_WIDTH-2:0], feedback};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
            word_q  <= seed_i; // first word out is the seed
            poly_q  <= poly_i;
        end else begin
            // valid may only drop after its word has gone
            if (!valid_q || ready_i) begin
                valid_q <= enable_i;
            end
            if (handshake) begin
                word_q <= word_next;
            end
        end
    end

    // zero seed gives a stuck zero stream

    assign valid_o = valid_q;
    assign word_o  = word_q;

endmodule

`default_nettype wire

/* hw/frame_tagger.sv */
// frame tagger
// counts accepted words and flags the last word of each frame
`timescale 1ns/1ns
`default_nettype none

module frame_tagger
    import lfsr_pkg::*;
    import crc_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rstn_i,
    input  wire logic [FRAME_LEN_WIDTH-1:0] frame_len_i,
    input  wire logic                       s_valid_i,
    input  wire lfsr_word_t                 s_word_i,
    output logic                            s_ready_o,
    output logic                            m_valid_o,
    output stream_beat_t                    m_beat_o,
    input  wire logic                       m_ready_i
);

    logic [FRAME_LEN_WIDTH-1:0] len_q;
    logic [FRAME_LEN_WIDTH-1:0] count_q; // position of the current word, from 1
    logic                       last;
    logic                       handshake;

    // no storage on the data path, back-pressure goes straight upstream
    assign s_ready_o = m_ready_i;
    assign m_valid_o = s_valid_i;
    assign handshake = s_valid_i & m_ready_i;

    // a length of 0 means 256: the counter rolls 255 -> 0 on the 256th word,
    // so the same compare covers it
    assign last = (count_q == len_q);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            len_q   <= frame_len_i;
            count_q <= FRAME_LEN_WIDTH'(1);
        end else if (handshake) begin
            if (last) begin
                count_q <= FRAME_LEN_WIDTH'(1); // next frame starts
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_comb begin
        m_beat_o      = '0;
        m_beat_o.data = s_word_i;
        m_beat_o.last = last;
    end

endmodule

`default_nettype wire

/* hw/crc_engine.sv */
// crc-16-ccitt engine on a pass-through stream
// one checksum and word count per frame reported a cycle after the last word
`timescale 1ns/1ns
`default_nettype none

module crc_engine
    import crc_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rstn_i,
    input  wire logic         s_valid_i,
    input  wire stream_beat_t s_beat_i,
    output logic              s_ready_o,
    output logic              m_valid_o,
    output stream_beat_t      m_beat_o,
    input  wire logic         m_ready_i,
    output logic              crc_valid_o,
    output crc_result_t       crc_result_o
);

    crc_t                       crc_q;
    crc_t                       crc_next;
    logic [FRAME_LEN_WIDTH-1:0] count_q;
    logic [FRAME_LEN_WIDTH-1:0] count_next;
    logic                       handshake;
    logic                       crc_valid_q;
    crc_result_t                result_q;

    // beats pass untouched while the engine watches them
    assign m_valid_o = s_valid_i;
    assign m_beat_o  = s_beat_i;
    assign s_ready_o = m_ready_i;

    assign handshake  = s_valid_i & m_ready_i;
    assign crc_next   = crc16_word(crc_q, s_beat_i.data);
    assign count_next = count_q + 1'b1; // wraps to 0 on a 256 word frame

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            crc_q       <= CRC_INIT;
            count_q     <= '0;
            crc_valid_q <= 1'b0;
        end else begin
            crc_valid_q <= 1'b0; // single cycle pulse
            if (handshake) begin
                if (s_beat_i.last) begin
                    crc_q       <= CRC_INIT; // ready for a beat next cycle
                    count_q     <= '0;
                    crc_valid_q <= 1'b1;
                end else begin
                    crc_q   <= crc_next;
                    count_q <= count_next;
                end
            end
        end
    end

    // final checksum and word count of the frame just closed
    always_ff @(posedge clk_i) begin
        if (handshake && s_beat_i.last) begin
            result_q.crc   <= crc_next;
            result_q.count <= count_next;
        end
    end

    assign crc_valid_o  = crc_valid_q;
    assign crc_result_o = result_q;

endmodule

`default_nettype wire

/* hw/prbs_crc_gen.sv */
// top level of the test-pattern generator
// lfsr source, frame tagger and crc engine in a chain
`timescale 1ns/1ns
`default_nettype none

module prbs_crc_gen
    import lfsr_pkg::*;
    import crc_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rstn_i,
    input  wire logic                       enable_i,
    input  wire lfsr_word_t                 seed_i,
    input  wire lfsr_word_t                 poly_i,
    input  wire logic [FRAME_LEN_WIDTH-1:0] frame_len_i,
    output logic                            m_valid_o,
    output stream_beat_t                    m_beat_o,
    input  wire logic                       m_ready_i,
    output logic                            crc_valid_o,
    output crc_result_t                     crc_result_o
);

    // source to tagger
    logic         src_valid;
    lfsr_word_t   src_word;
    logic         src_ready;

    // tagger to crc engine
    logic         tag_valid;
    stream_beat_t tag_beat;
    logic         tag_ready;

    lfsr_source u_lfsr_source (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (enable_i),
        .seed_i   (seed_i),
        .poly_i   (poly_i),
        .valid_o  (src_valid),
        .word_o   (src_word),
        .ready_i  (src_ready)
    );

    frame_tagger u_frame_tagger (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .frame_len_i (frame_len_i),
        .s_valid_i   (src_valid),
        .s_word_i    (src_word),
        .s_ready_o   (src_ready),
        .m_valid_o   (tag_valid),
        .m_beat_o    (tag_beat),
        .m_ready_i   (tag_ready)
    );

    crc_engine u_crc_engine (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .s_valid_i    (tag_valid),
        .s_beat_i     (tag_beat),
        .s_ready_o    (tag_ready),
        .m_valid_o    (m_valid_o),
        .m_beat_o     (m_beat_o),
        .m_ready_i    (m_ready_i),
        .crc_valid_o  (crc_valid_o),
        .crc_result_o (crc_result_o)
    );

endmodule

`default_nettype wire

/* tb/tb_models.svh */
// reference models for the testbench
// lfsr step and crc-16-ccitt folded one byte at a time
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// next lfsr word, parity of tapped bits shifted in at bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] word, input logic [15:0] taps);
    logic fb;
    fb = 1'b0;
    for (int b = 0; b < 16; b++) begin
        if (taps[b]) begin
            fb = fb ^ word[b];
        end
    end
    return {word[14:0], fb};
endfunction

// classic table-free byte update, data xored into the top byte first
function automatic logic [15:0] crc_fold_byte(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc ^ {data, 8'h00};
    for (int k = 0; k < 8; k++) begin
        if (c[15]) begin
            c = {c[14:0], 1'b0} ^ 16'h1021;
        end else begin
            c = {c[14:0], 1'b0};
        end
    end
    return c;
endfunction

// a word is its high byte followed by its low byte
function automatic logic [15:0] crc_fold_word(input logic [15:0] crc, input logic [15:0] data);
    logic [15:0] c;
    c = crc_fold_byte(crc, data[15:8]);
    c = crc_fold_byte(c, data[7:0]);
    return c;
endfunction

// programmed frame length in words
function automatic int frame_words(input logic [7:0] len);
    if (len == 8'd0) begin
        return 256;
    end
    return int'(len);
endfunction

`endif

/* tb/tb_prbs_crc_gen.sv */
// testbench for the pattern source with frame checksums
// model scoreboard, random back-pressure and concurrent assertions
`timescale 1ns/1ns
`default_nettype none

module tb_prbs_crc_gen
    import lfsr_pkg::*;
    import crc_pkg::*;
();

    `include "tb_models.svh"

    logic                       clk_i;
    logic                       rstn_i;
    logic                       enable_i;
    lfsr_word_t                 seed_i;
    lfsr_word_t                 poly_i;
    logic [FRAME_LEN_WIDTH-1:0] frame_len_i;
    logic                       m_ready_i;
    logic                       m_valid_o;
    stream_beat_t               m_beat_o;
    logic                       crc_valid_o;
    crc_result_t                crc_result_o;

    int   ready_mode;         // 1 for always ready and 2 for random
    int   error_count  = 0;
    int   test_count   = 0;
    int   failed_tests = 0;
    int   test_start_errors = 0;
    logic idle_check;         // valid must stay low while set

    // model state advanced on every output handshake
    logic [15:0] exp_word;
    logic [15:0] exp_taps;
    int          exp_len;
    int          exp_pos;     // position of the next word in its frame
    logic [15:0] run_crc;
    logic [15:0] res_crc;
    int          res_count;
    logic        exp_pulse;
    int          words_seen  = 0;
    int          frames_seen = 0;
    logic        exp_last;
    logic        handshake;

    assign handshake = m_valid_o & m_ready_i;
    assign exp_last  = (exp_pos == exp_len);

    prbs_crc_gen dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .enable_i     (enable_i),
        .seed_i       (seed_i),
        .poly_i       (poly_i),
        .frame_len_i  (frame_len_i),
        .m_valid_o    (m_valid_o),
        .m_beat_o     (m_beat_o),
        .m_ready_i    (m_ready_i),
        .crc_valid_o  (crc_valid_o),
        .crc_result_o (crc_result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // output back-pressure
    initial begin : ready_driver
        void'($urandom(32'hf65a_8942));
        m_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            case (ready_mode)
                1:       m_ready_i = 1'b1;
                default: m_ready_i = (($urandom % 4) != 0); // about 3 in 4
            endcase
        end
    end

    always @(posedge clk_i) begin : model_update
        logic [15:0] folded;
        folded = crc_fold_word(run_crc, exp_word);
        if (!rstn_i) begin
            exp_word  <= seed_i;
            exp_taps  <= poly_i;
            exp_len   <= frame_words(frame_len_i);
            exp_pos   <= 1;
            run_crc   <= 16'hFFFF;
            exp_pulse <= 1'b0;
        end else begin
            exp_pulse <= handshake && exp_last;
            if (handshake) begin
                exp_word   <= lfsr_next(exp_word, exp_taps);
                words_seen <= words_seen + 1;
                if (exp_last) begin
                    res_crc     <= folded;
                    res_count   <= exp_pos;
                    run_crc     <= 16'hFFFF;
                    exp_pos     <= 1;
                    frames_seen <= frames_seen + 1;
                end else begin
                    run_crc <= folded;
                    exp_pos <= exp_pos + 1;
                end
            end
        end
    end

    task automatic log_mismatch(input string msg);
        error_count++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        error_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    word_seq: assert property (@(posedge clk_i) disable iff (!rstn_i)
        handshake |-> m_beat_o.data == exp_word)
        else log_mismatch($sformatf("word %h, expected %h",
                                    $sampled(m_beat_o.data), $sampled(exp_word)));

    last_flag: assert property (@(posedge clk_i) disable iff (!rstn_i)
        handshake |-> m_beat_o.last == exp_last)
        else log_mismatch($sformatf("last flag %b at frame position %0d",
                                    $sampled(m_beat_o.last), $sampled(exp_pos)));

    // a stalled beat holds until taken
    stall_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o)))
        else log_mismatch("stalled beat changed or valid dropped");

    crc_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        crc_valid_o == exp_pulse)
        else log_mismatch($sformatf("crc_valid_o %b, expected %b",
                                    $sampled(crc_valid_o), $sampled(exp_pulse)));

    crc_value: assert property (@(posedge clk_i) disable iff (!rstn_i)
        crc_valid_o |-> (crc_result_o.crc == res_crc && crc_result_o.count == 8'(res_count)))
        else log_mismatch($sformatf("crc %h count %0d, expected %h count %0d",
                                    $sampled(crc_result_o.crc), $sampled(crc_result_o.count),
                                    $sampled(res_crc), 8'($sampled(res_count))));

    reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |=> (!m_valid_o && !crc_valid_o))
        else log_mismatch("valid output high right after reset");

    idle_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        idle_check |-> !m_valid_o)
        else log_mismatch("m_valid_o high while disabled");

    // settings are taken only while reset is held
    task automatic apply_reset(input lfsr_word_t seed, input lfsr_word_t taps,
                               input logic [7:0] len, input logic en);
        assert (seed != '0) else log_failure("zero seed would give a stuck stream");
        @(posedge clk_i);
        #1;
        rstn_i      = 1'b0;
        seed_i      = seed;
        poly_i      = taps;
        frame_len_i = len;
        enable_i    = en;
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
    endtask

    task automatic wait_words(input int count, input int limit);
        int target;
        int cycles;
        target = words_seen + count;
        cycles = 0;
        while (words_seen < target && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (words_seen < target) begin
            log_failure($sformatf("no %0d words within %0d cycles", count, limit));
        end
    endtask

    task automatic wait_frames(input int count, input int limit);
        int target;
        int cycles;
        target = frames_seen + count;
        cycles = 0;
        while (frames_seen < target && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (frames_seen < target) begin
            log_failure($sformatf("no %0d frames within %0d cycles", count, limit));
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_start_errors;
        test_count++;
        if (errs == 0) begin
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, errs);
        end
        test_start_errors = error_count;
    endtask

    initial begin : main
        logic [15:0] crc;
        rstn_i      = 1'b0;
        enable_i    = 1'b0;
        seed_i      = 16'h0001;
        poly_i      = LFSR_DEFAULT_POLY;
        frame_len_i = 8'd5;
        idle_check  = 1'b0;
        ready_mode  = 1;

        // "123456789" as four words and a final byte
        crc = 16'hFFFF;
        crc = crc_fold_word(crc, 16'h3132);
        crc = crc_fold_word(crc, 16'h3334);
        crc = crc_fold_word(crc, 16'h3536);
        crc = crc_fold_word(crc, 16'h3738);
        crc = crc_fold_byte(crc, 8'h39);
        assert (crc == 16'h29B1)
            else log_mismatch($sformatf("model check value %h, expected 29b1", crc));
        finish_test("crc model");

        apply_reset(16'hACE1, LFSR_DEFAULT_POLY, 8'd5, 1'b1);
        wait_words(64, 200);
        finish_test("sequence");

        ready_mode = 2;
        wait_words(300, 2000);
        finish_test("back-pressure");

        wait_frames(20, 1000);
        finish_test("framing len 5");

        apply_reset(16'h5EED, LFSR_DEFAULT_POLY, 8'd0, 1'b1); // 256 words
        wait_frames(3, 5000);
        finish_test("framing len 256");

        // one word frames give back to back results
        ready_mode = 1;
        apply_reset(16'h0BAD, LFSR_DEFAULT_POLY, 8'd1, 1'b1);
        wait_frames(16, 100);
        ready_mode = 2;
        apply_reset(16'hC0DE, LFSR_DEFAULT_POLY, 8'd7, 1'b1);
        wait_frames(30, 1000);
        finish_test("checksum");

        apply_reset(16'h1D0F, 16'hD008, 8'd3, 1'b0); // another tap mask
        idle_check = 1'b1;
        repeat (20) @(posedge clk_i);
        #1;
        idle_check = 1'b0;
        enable_i   = 1'b1;
        wait_words(50, 400);
        finish_test("reset and enable");

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* prbs_crc_gen.f */
+incdir+tb
hw/lfsr_pkg.sv
hw/crc_pkg.sv
hw/lfsr_source.sv
hw/frame_tagger.sv
hw/crc_engine.sv
hw/prbs_crc_gen.sv
tb/tb_prbs_crc_gen.sv
